/* include/aurora_tx_macros.svh */
`ifndef AURORA_TX_MACROS_SVH
`define AURORA_TX_MACROS_SVH

// Geometry of one packet as it is read from the FIFO
`define AURORA_PACKET_BITS 256
`define AURORA_LANE_BITS 32     // One Aurora lane carries one 32-bit word per beat
`define AURORA_HDR_BITS 64      // Header goes out as two lane words

// Payload words that fit behind the header
`define AURORA_MAX_WORDS 6
`define AURORA_CNT_BITS 3       // Wide enough to count up to the payload capacity
`define AURORA_WORD_CNT_BITS 14 // Byte count with its two low bits dropped

// Field positions inside the packet, given by their top bit
`define AURORA_BUS_ID_MSB 255
`define AURORA_SRC_ID_MSB 247
`define AURORA_VALID_BYTES_MSB 207

`endif

/* hdl/aurora_tx_pkg.sv */
package aurora_tx_pkg;

    // One-hot framer states
    typedef enum logic [8:0] {
        idle_rst     = 9'b000000001, // Entered right after reset
        wait_ready   = 9'b000000010, // Waits for a packet and a ready link
        read_fifo    = 9'b000000100, // Loads the packet and pops the FIFO
        filter       = 9'b000001000, // Decides to keep or drop the packet
        drop_wait    = 9'b000010000, // Lets the FIFO flags settle after a drop
        send_hdr0    = 9'b000100000, // First header word with the sequence number
        send_hdr1    = 9'b001000000,
        send_payload = 9'b010000000,
        send_last    = 9'b100000000  // Final word with tlast
    } tx_state_e;

    // Commands the sequencer issues every cycle
    typedef struct packed {
        logic load;        // Capture dout into the shift buffer
        logic shift;       // Move the next word to the top
        logic count_en;    // Count one sent beat
        logic clear;       // Empty the buffer and its counters
        logic stamp_sel;   // Replace the bus id with the sequence number
        logic seq_advance; // One packet has been sent
        logic tvalid;
        logic tlast;
        logic rd_en;       // Pop the FIFO
    } tx_ctrl_t;

    // Top 64 bits of a packet
    typedef struct packed {
        logic [7:0]  bus_id;
        logic [7:0]  src_id;      // FPGA that first sent the packet
        logic [31:0] reserved;
        logic [15:0] valid_bytes; // Always a multiple of four
    } pkt_header_t;

endpackage

/* hdl/tx_sequencer.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

module tx_sequencer #(
    parameter logic [7:0] target_fpga_id = 8'h00
) (
    input  logic                             user_clk,
    input  logic                             reset_TX_RX_Block,
    input  logic                             empty,
    input  logic                             s_axi_tx_tready,
    input  aurora_tx_pkg::pkt_header_t       hdr,
    input  logic [`AURORA_WORD_CNT_BITS-1:0] word_cnt,
    input  logic [`AURORA_CNT_BITS-1:0]      beat_cnt,
    output aurora_tx_pkg::tx_ctrl_t          ctrl
);

    logic                             empty_q;     // Registered FIFO empty flag
    logic                             tready_q;    // Registered link ready
    aurora_tx_pkg::tx_state_e         state_q;
    aurora_tx_pkg::tx_state_e         state_d;
    logic                             drop_pkt;
    logic [`AURORA_WORD_CNT_BITS-1:0] beat_ext;    // Beat count at the word count width

    // Words are bytes over four, so the two low bits of the byte count are skipped
    assign drop_pkt = (hdr.src_id == target_fpga_id) ||
                      (hdr.valid_bytes[15:2] == '0); // Loop guard or empty packet
    assign beat_ext = {{(`AURORA_WORD_CNT_BITS-`AURORA_CNT_BITS){1'b0}}, beat_cnt};

    //////////////////////////////////////////////////
    // Input sampling and state register
    //////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            empty_q  <= 1'b1; // Treat the FIFO as empty until it has been seen
            tready_q <= 1'b0;
            state_q  <= aurora_tx_pkg::idle_rst;
        end else begin
            empty_q  <= empty;
            tready_q <= s_axi_tx_tready;
            state_q  <= state_d;
        end
    end

    //////////////////////////////////////////////////
    // Next state and per-state commands
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        ctrl    = '0;
        case (state_q)
            aurora_tx_pkg::idle_rst: begin
                ctrl.clear = 1'b1;
                state_d    = aurora_tx_pkg::wait_ready;
            end
            aurora_tx_pkg::wait_ready: begin
                ctrl.clear = 1'b1; // Buffer stays empty while nothing is pending
                // A started burst never stalls because tready only counts here
                if (tready_q && !empty_q) state_d = aurora_tx_pkg::read_fifo;
            end
            aurora_tx_pkg::read_fifo: begin
                ctrl.load      = 1'b1;
                ctrl.rd_en     = 1'b1; // Single pop per accepted packet
                ctrl.stamp_sel = 1'b1;
                state_d        = aurora_tx_pkg::filter;
            end
            aurora_tx_pkg::filter: begin
                ctrl.stamp_sel = 1'b1; // Held so it lines up with the first word
                state_d = drop_pkt ? aurora_tx_pkg::drop_wait : aurora_tx_pkg::send_hdr0;
            end
            aurora_tx_pkg::drop_wait: begin
                // Gives the pop time to show up on the sampled empty flag
                ctrl.clear = 1'b1;
                state_d    = aurora_tx_pkg::wait_ready;
            end
            aurora_tx_pkg::send_hdr0, aurora_tx_pkg::send_hdr1,
            aurora_tx_pkg::send_payload: begin
                ctrl.tvalid   = 1'b1;
                ctrl.shift    = 1'b1;
                ctrl.count_en = 1'b1;
                if (state_q == aurora_tx_pkg::send_hdr0) begin
                    state_d = aurora_tx_pkg::send_hdr1;
                end else if (state_q == aurora_tx_pkg::send_hdr1) begin
                    // With one payload word that word is already the last one
                    state_d = (word_cnt == `AURORA_WORD_CNT_BITS'd1) ?
                              aurora_tx_pkg::send_last : aurora_tx_pkg::send_payload;
                end else if (beat_ext == word_cnt) begin
                    state_d = aurora_tx_pkg::send_last; // Two header beats lead the count
                end
            end
            aurora_tx_pkg::send_last: begin
                ctrl.tvalid      = 1'b1;
                ctrl.tlast       = 1'b1;
                ctrl.clear       = 1'b1;
                ctrl.seq_advance = 1'b1; // Next packet takes the next number
                state_d          = aurora_tx_pkg::wait_ready;
            end
            default: begin
                ctrl.clear = 1'b1;
                state_d    = aurora_tx_pkg::idle_rst;
            end
        endcase
    end

    // The tlast beat comes once both header words and all payload words but one were counted
    tlast_ends_full_burst: assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        ctrl.tlast |-> ctrl.tvalid && (beat_ext == word_cnt + `AURORA_WORD_CNT_BITS'd1));

endmodule

/* hdl/packet_shift_buffer.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

module packet_shift_buffer (
    input  logic                              user_clk,
    input  logic                              reset_TX_RX_Block,
    input  logic [`AURORA_PACKET_BITS-1:0]    dout,
    input  aurora_tx_pkg::tx_ctrl_t           ctrl,
    output aurora_tx_pkg::pkt_header_t        hdr,
    output logic [`AURORA_WORD_CNT_BITS-1:0]  word_cnt,
    output logic [`AURORA_CNT_BITS-1:0]       beat_cnt,
    output logic [`AURORA_LANE_BITS-1:0]      head_word
);

    logic [`AURORA_PACKET_BITS-1:0] pkt_q;       // Whole packet, next word at the top
    logic                           wc_store_q;  // Load delayed by one cycle

    assign hdr       = pkt_q[`AURORA_BUS_ID_MSB -: `AURORA_HDR_BITS];
    assign head_word = pkt_q[`AURORA_PACKET_BITS-1 -: `AURORA_LANE_BITS];

    //////////////////////////////////////////////////
    // Packet register
    //////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            pkt_q <= '0;
        end else if (ctrl.load) begin
            pkt_q <= dout; // Whole packet in a single beat
        end else if (ctrl.shift) begin
            // Sent word drops off the top and zeros fill from below
            pkt_q <= {pkt_q[`AURORA_PACKET_BITS-`AURORA_LANE_BITS-1:0],
                      {`AURORA_LANE_BITS{1'b0}}};
        end
    end

    // Word count and beat counter
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            wc_store_q <= 1'b0;
        end else begin
            wc_store_q <= ctrl.load;
        end
    end

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            word_cnt <= '0;
        end else if (wc_store_q) begin
            // Bits 207..194 give the count of 32-bit words
            word_cnt <= pkt_q[`AURORA_VALID_BYTES_MSB -: `AURORA_WORD_CNT_BITS];
        end
    end

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            beat_cnt <= '0;
        end else if (ctrl.count_en) begin
            beat_cnt <= beat_cnt + 1'b1; // One step per sent beat
        end
    end

    // A new packet must never land while the previous one is shifting out
    load_not_during_shift: assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        !(ctrl.load && ctrl.shift));

endmodule

/* hdl/seq_stamp_output.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

module seq_stamp_output (
    input  logic                         user_clk,
    input  logic                         reset_TX_RX_Block,
    input  aurora_tx_pkg::tx_ctrl_t      ctrl,
    input  logic [`AURORA_LANE_BITS-1:0] head_word,
    output logic                         rd_en,
    output logic [`AURORA_LANE_BITS-1:0] s_axi_tx_tdata,
    output logic                         s_axi_tx_tvalid,
    output logic                         s_axi_tx_tlast
);

    logic       stamp_q;  // Select lined up with the first header word
    logic [7:0] seq_cnt;  // Number of packets sent so far, mod 256
    logic [7:0] top_byte;

    // The far side sees a running packet number in place of the bus id
    assign top_byte = stamp_q ? seq_cnt : head_word[`AURORA_LANE_BITS-1 -: 8];

    //////////////////////////////////////////////////
    // Sequence counter
    //////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            seq_cnt <= 8'd0;
        end else if (ctrl.seq_advance) begin
            seq_cnt <= seq_cnt + 1'b1; // Wraps from 255 back to 0
        end
    end

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            stamp_q         <= 1'b0;
            rd_en           <= 1'b0;
            s_axi_tx_tdata  <= '0;
            s_axi_tx_tvalid <= 1'b0;
            s_axi_tx_tlast  <= 1'b0;
        end else begin
            stamp_q         <= ctrl.stamp_sel;
            rd_en           <= ctrl.rd_en; // FIFO pops one cycle after the load
            s_axi_tx_tdata  <= {top_byte, head_word[`AURORA_LANE_BITS-9:0]};
            s_axi_tx_tvalid <= ctrl.tvalid;
            s_axi_tx_tlast  <= ctrl.tlast;
        end
    end

endmodule

/* hdl/fifo_to_aurora_tx.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

// Single-lane framer from a packet FIFO to an Aurora AXI4-Stream transmit port
module fifo_to_aurora_tx #(
    parameter logic [7:0] target_fpga_id = 8'h00 // Id of the FPGA on the far end of the link
) (
    input  logic                           user_clk,
    input  logic                           reset_TX_RX_Block,
    input  logic                           empty,
    output logic                           rd_en,
    input  logic [`AURORA_PACKET_BITS-1:0] dout,
    output logic [`AURORA_LANE_BITS-1:0]   s_axi_tx_tdata,
    output logic                           s_axi_tx_tlast,
    input  logic                           s_axi_tx_tready,
    output logic                           s_axi_tx_tvalid
);

    aurora_tx_pkg::tx_ctrl_t             ctrl;      // Per-cycle commands from the FSM
    aurora_tx_pkg::pkt_header_t          hdr;       // Header of the buffered packet
    logic [`AURORA_WORD_CNT_BITS-1:0]    word_cnt;  // Payload words of the buffered packet
    logic [`AURORA_CNT_BITS-1:0]         beat_cnt;
    logic [`AURORA_LANE_BITS-1:0]        head_word; // Word that goes out next

    tx_sequencer #(
        .target_fpga_id (target_fpga_id)
    ) u_tx_sequencer (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .hdr               (hdr),
        .word_cnt          (word_cnt),
        .beat_cnt          (beat_cnt),
        .ctrl              (ctrl)
    );

    packet_shift_buffer u_packet_shift_buffer (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .dout              (dout),
        .ctrl              (ctrl),
        .hdr               (hdr),
        .word_cnt          (word_cnt),
        .beat_cnt          (beat_cnt),
        .head_word         (head_word)
    );

    // All outgoing signals leave from registers in here
    seq_stamp_output u_seq_stamp_output (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .ctrl              (ctrl),
        .head_word         (head_word),
        .rd_en             (rd_en),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic user_clk,
    output logic reset_TX_RX_Block
);

    initial begin
        user_clk          = 1'b0;
        reset_TX_RX_Block = 1'b1; // Held for the first two rising edges
        repeat (2) @(posedge user_clk);
        reset_TX_RX_Block <= 1'b0;
    end

    always #5 user_clk = ~user_clk; // 10 ns period

endmodule

/* dv/tx_stream_checker.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

module tx_stream_checker (
    input logic                         user_clk,
    input logic                         reset_TX_RX_Block,
    input logic [`AURORA_LANE_BITS-1:0] s_axi_tx_tdata,
    input logic                         s_axi_tx_tvalid,
    input logic                         s_axi_tx_tlast,
    input logic                         s_axi_tx_tready,
    input logic                         rd_en,
    input logic                         check_idle
);

    logic [`AURORA_LANE_BITS:0] exp_q[$]; // Expected beats with tlast in the top bit
    logic [`AURORA_LANE_BITS:0] exp_beat;
    logic                       in_burst;  // A beat without tlast was seen
    logic                       rd_en_q;
    logic                       tvalid_q;
    int                         low_run;   // Cycles that tready has been low
    int                         error_count = 0;
    int                         beat_count = 0;
    int                         packet_count = 0;
    int                         rd_pulses = 0;

    // Called by the testbench model when it pops a packet that will be sent
    task automatic push_beat(input logic [`AURORA_LANE_BITS:0] beat);
        exp_q.push_back(beat);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    //////////////////////////////////////////////////
    // Per-cycle comparison
    //////////////////////////////////////////////////

    always @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            in_burst = 1'b0;
            rd_en_q  = 1'b0;
            tvalid_q = 1'b0;
            low_run  = 0;
        end else begin
            if (check_idle && (s_axi_tx_tvalid || s_axi_tx_tlast || rd_en)) begin
                error_count++;
                $display("ERR %0t: output active while the FIFO is empty", $time);
            end
            if (rd_en && rd_en_q) begin
                error_count++; // Each pop must be a single cycle
                $display("ERR %0t: rd_en high for more than one cycle", $time);
            end
            if (rd_en && !rd_en_q) rd_pulses++;
            if (in_burst && !s_axi_tx_tvalid) begin
                error_count++;
                $display("ERR %0t: gap inside a burst", $time);
            end
            // A burst may only start shortly after tready was last high
            if (s_axi_tx_tvalid && !tvalid_q && low_run >= 10) begin
                error_count++;
                $display("ERR %0t: burst started after tready low for %0d cycles",
                         $time, low_run);
            end
            if (s_axi_tx_tvalid) begin
                beat_count++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("ERR %0t: unexpected beat %h", $time, s_axi_tx_tdata);
                end else begin
                    exp_beat = exp_q.pop_front();
                    if ({s_axi_tx_tlast, s_axi_tx_tdata} != exp_beat) begin
                        error_count++;
                        $display("ERR %0t: beat got last=%b data=%h, expected last=%b data=%h",
                                 $time, s_axi_tx_tlast, s_axi_tx_tdata,
                                 exp_beat[`AURORA_LANE_BITS], exp_beat[`AURORA_LANE_BITS-1:0]);
                    end
                end
                if (s_axi_tx_tlast) packet_count++;
                in_burst = !s_axi_tx_tlast;
            end
            low_run  = s_axi_tx_tready ? 0 : low_run + 1;
            rd_en_q  = rd_en;
            tvalid_q = s_axi_tx_tvalid;
        end
    end

    // One closing line with every count
    task automatic report(input int expected_pulses, input int tb_errors);
        if (rd_pulses != expected_pulses) begin
            error_count++;
            $display("Saw %0d rd_en pulses for %0d packets", rd_pulses, expected_pulses);
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected beats never arrived", exp_q.size());
        end
        error_count += tb_errors;
        $display("Summary: beats=%0d packets=%0d rd_en pulses=%0d of %0d errors=%0d",
                 beat_count, packet_count, rd_pulses, expected_pulses, error_count);
    endtask

endmodule

/* dv/tb_fifo_to_aurora_tx.sv */
`timescale 1ns/1ps
`include "aurora_tx_macros.svh"

module tb_fifo_to_aurora_tx;

    localparam logic [7:0] target_id = 8'h5a; // Far FPGA whose packets are dropped

    logic                           user_clk;
    logic                           reset_TX_RX_Block;
    logic                           empty;
    logic                           rd_en;
    logic [`AURORA_PACKET_BITS-1:0] dout;
    logic [`AURORA_LANE_BITS-1:0]   s_axi_tx_tdata;
    logic                           s_axi_tx_tlast;
    logic                           s_axi_tx_tready;
    logic                           s_axi_tx_tvalid;
    logic                           check_idle;

    logic [`AURORA_PACKET_BITS-1:0] fifo_q[$]; // FIFO model, head is dout
    logic [7:0]                     seq_model = 8'd0;
    logic                           timed_out = 1'b0;
    int                             ready_mode = 0; // 0 random, 1 held low, 2 held high
    int                             tb_errors = 0;
    int                             total_packets = 0;
    int                             pop_count = 0;
    int                             idle_run = 0;

    tb_clk_gen u_clk_gen (.user_clk(user_clk), .reset_TX_RX_Block(reset_TX_RX_Block));

    fifo_to_aurora_tx #(.target_fpga_id(target_id)) uut (
        .user_clk(user_clk), .reset_TX_RX_Block(reset_TX_RX_Block),
        .empty(empty), .rd_en(rd_en), .dout(dout),
        .s_axi_tx_tdata(s_axi_tx_tdata), .s_axi_tx_tlast(s_axi_tx_tlast),
        .s_axi_tx_tready(s_axi_tx_tready), .s_axi_tx_tvalid(s_axi_tx_tvalid)
    );

    tx_stream_checker chk (
        .user_clk(user_clk), .reset_TX_RX_Block(reset_TX_RX_Block),
        .s_axi_tx_tdata(s_axi_tx_tdata), .s_axi_tx_tvalid(s_axi_tx_tvalid),
        .s_axi_tx_tlast(s_axi_tx_tlast), .s_axi_tx_tready(s_axi_tx_tready),
        .rd_en(rd_en), .check_idle(check_idle)
    );

    // Random packet with a chosen word count and a source id that is the target or any other
    function automatic logic [`AURORA_PACKET_BITS-1:0] make_packet(input bit from_target,
                                                                   input int unsigned n);
        logic [`AURORA_PACKET_BITS-1:0] pkt;
        aurora_tx_pkg::pkt_header_t     hdr;
        logic [31:0]                    r;
        for (int i = 0; i < 8; i++) pkt[32*i +: 32] = $urandom();
        hdr = pkt[`AURORA_BUS_ID_MSB -: `AURORA_HDR_BITS];
        r = $urandom();
        hdr.src_id      = from_target ? target_id : ((r[7:0] == target_id) ? 8'h01 : r[7:0]);
        hdr.valid_bytes = 16'(4 * n);
        pkt[`AURORA_BUS_ID_MSB -: `AURORA_HDR_BITS] = hdr;
        return pkt;
    endfunction

    // Reference for a popped packet; kept packets go to the checker as expected beats
    task automatic model_packet(input logic [`AURORA_PACKET_BITS-1:0] pkt);
        aurora_tx_pkg::pkt_header_t hdr;
        int                         n;
        hdr = pkt[`AURORA_BUS_ID_MSB -: `AURORA_HDR_BITS];
        n   = int'(hdr.valid_bytes[15:2]);
        if (hdr.src_id == target_id || n == 0) return; // Dropped packets leave the sequence alone
        chk.push_beat({1'b0, seq_model, pkt[`AURORA_SRC_ID_MSB -: 24]});
        for (int k = 1; k <= n + 1; k++) begin
            chk.push_beat({(k == n + 1), pkt[`AURORA_PACKET_BITS - 1 - 32*k -: 32]});
        end
        seq_model = seq_model + 8'd1;
    endtask

    // One clock that serves the FIFO model and drives every input on the edge
    task automatic tick();
        @(posedge user_clk);
        if (rd_en) begin
            if (fifo_q.size() == 0) begin
                tb_errors++;
                $display("rd_en pulse seen while the FIFO model was empty");
            end else begin
                pop_count++;
                model_packet(fifo_q.pop_front());
            end
        end
        idle_run = (s_axi_tx_tvalid || rd_en) ? 0 : idle_run + 1;
        empty <= (fifo_q.size() == 0);
        dout  <= (fifo_q.size() == 0) ? '0 : fifo_q[0];
        if (ready_mode == 1) s_axi_tx_tready <= 1'b0;
        else if (ready_mode == 2) s_axi_tx_tready <= 1'b1;
        else if (!s_axi_tx_tvalid) s_axi_tx_tready <= ($urandom() % 4) != 0;
    endtask

    // Runs until the FIFO and the expected queue are empty and the outputs are quiet
    task automatic drain(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out &&
               !(fifo_q.size() == 0 && chk.pending() == 0 && idle_run >= 10)) begin
            tick();
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
                tb_errors++;
                $display("Timeout: %s did not finish within %0d cycles", what, limit);
            end
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(28));
        empty           = 1'b1;
        dout            = '0;
        s_axi_tx_tready = 1'b0;
        check_idle      = 1'b0;

        cycles = 0;
        do begin
            @(posedge user_clk);
            cycles++;
            if (cycles > 20) begin
                timed_out = 1'b1;
                tb_errors++;
                $display("Timeout: reset never released");
            end
        end while (reset_TX_RX_Block && !timed_out);

        if (!timed_out) begin
            // Nothing may leave the DUT while the FIFO is empty, even with tready high
            ready_mode = 2;
            check_idle <= 1'b1;
            repeat (20) tick();
            check_idle <= 1'b0;

            // Random packets with some from the target id and some without payload
            ready_mode = 0;
            for (int i = 0; i < 40; i++) begin
                fifo_q.push_back(make_packet(($urandom() % 4) == 0,
                                             $urandom_range(`AURORA_MAX_WORDS, 0)));
            end
            total_packets += 40;
            drain(8000, "random packet run");
        end

        ///////////////////////////////////////////////
        // Back-pressure with a full FIFO
        ///////////////////////////////////////////////
        if (!timed_out) begin
            ready_mode = 1;
            repeat (5) tick();
            for (int i = 0; i < 6; i++) begin
                fifo_q.push_back(make_packet(1'b0, $urandom_range(`AURORA_MAX_WORDS, 1)));
            end
            total_packets += 6;
            repeat (50) tick();
            if (fifo_q.size() != 6) begin
                tb_errors++;
                $display("Packets were read while tready was held low");
            end
            ready_mode = 2;
            drain(2000, "back-pressure release");
        end

        // Enough one-word packets for the sequence number to wrap
        if (!timed_out) begin
            ready_mode = 0;
            for (int i = 0; i < 260; i++) fifo_q.push_back(make_packet(1'b0, 1));
            total_packets += 260;
            drain(20000, "sequence wrap run");
        end

        if (pop_count != total_packets) begin
            tb_errors++;
            $display("Popped %0d of %0d packets", pop_count, total_packets);
        end
        chk.report(total_packets, tb_errors);
        if (chk.error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
hdl/aurora_tx_pkg.sv
hdl/tx_sequencer.sv
hdl/packet_shift_buffer.sv
hdl/seq_stamp_output.sv
hdl/fifo_to_aurora_tx.sv
dv/tb_clk_gen.sv
dv/tx_stream_checker.sv
dv/tb_fifo_to_aurora_tx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module tb_fifo_to_aurora_tx -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
